// ==== src/board_pkg.sv ====
package board_pkg;

    // Board I/O widths
    localparam int w_key   = 2;
    localparam int w_sw    = 9;
    localparam int w_led   = 9;
    localparam int w_digit = 6;

    typedef logic [w_key - 1:0] key_t;
    typedef logic [w_sw  - 1:0] sw_t;
    typedef logic [w_led - 1:0] led_t;
    typedef logic [7:0]         seg_t;    // One seven-segment digit with dot

    // Default clock figures
    localparam int clk_mhz             = 50;
    localparam int default_tick_period = 50_000_000;    // One tick per second

    typedef logic [23:0] count_t;         // Six hex digits

endpackage

// ==== src/display_pkg.sv ====
package display_pkg;

    import board_pkg::*;

    //--------------------------------------------------------------------------
    // VGA 640x480 geometry in pixels and lines

    localparam int screen_width  = 640;
    localparam int screen_height = 480;

    localparam int h_front = 16;
    localparam int h_sync  = 96;
    localparam int h_back  = 48;
    localparam int h_total = screen_width + h_front + h_sync + h_back;

    localparam int v_front = 10;
    localparam int v_sync  = 2;
    localparam int v_back  = 33;
    localparam int v_total = screen_height + v_front + v_sync + v_back;

    localparam int pixel_div = 2;         // System clocks per pixel

    typedef logic [9:0] x_t;
    typedef logic [9:0] y_t;

    typedef logic [3:0] color_t;

    typedef struct packed
    {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    //--------------------------------------------------------------------------
    // Hex glyphs, active high, bit 7 is segment a and bit 0 the dot

    function automatic seg_t hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;   // F
        endcase
    endfunction

endpackage

// ==== src/vga_if.sv ====
`timescale 1ns/1ps

interface vga_if
    import display_pkg::*;
();

    x_t   x;              // Current column
    y_t   y;              // Current line
    logic hsync;          // Active low
    logic vsync;          // Active low
    logic display_on;

    modport source
    (
        output x, y, hsync, vsync, display_on
    );

    modport sink
    (
        input  x, y, hsync, vsync, display_on
    );

endinterface

// ==== src/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen
    import board_pkg::*;
#(
    parameter int period = default_tick_period
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int w_cnt = $clog2(period + 1);

    logic [w_cnt - 1:0] cnt;    // Cycles left before the next pulse

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= w_cnt'(period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(period - 1);   // Reload and pulse
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
    import display_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    vga_if.source vga
);

    localparam int w_pix = (pixel_div > 1) ? $clog2(pixel_div) : 1;

    logic [w_pix - 1:0] pix_cnt;
    logic               pix_en;
    x_t                 h_cnt;
    y_t                 v_cnt;

    assign pix_en = (pix_cnt == w_pix'(pixel_div - 1));

    // Pixel enable divider
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pix_cnt <= '0;
        else if (pix_en)
            pix_cnt <= '0;
        else
            pix_cnt <= pix_cnt + 1'b1;
    end

    //--------------------------------------------------------------------------
    // Raster counters

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (pix_en)
        begin
            if (h_cnt == x_t'(h_total - 1))
            begin
                h_cnt <= '0;
                if (v_cnt == y_t'(v_total - 1))
                    v_cnt <= '0;              // End of frame
                else
                    v_cnt <= v_cnt + 1'b1;
            end
            else
            begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    //--------------------------------------------------------------------------
    // Registered position, sync and blanking, all aligned

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            vga.x          <= '0;
            vga.y          <= '0;
            vga.hsync      <= 1'b1;
            vga.vsync      <= 1'b1;
            vga.display_on <= 1'b0;
        end
        else
        begin
            vga.x          <= h_cnt;
            vga.y          <= v_cnt;
            vga.hsync      <= !(h_cnt >= x_t'(screen_width + h_front)
                                && h_cnt < x_t'(screen_width + h_front + h_sync));
            vga.vsync      <= !(v_cnt >= y_t'(screen_height + v_front)
                                && v_cnt < y_t'(screen_height + v_front + v_sync));
            vga.display_on <= (h_cnt < x_t'(screen_width))
                              && (v_cnt < y_t'(screen_height));
        end
    end

endmodule

// ==== src/seg7_scanner.sv ====
`timescale 1ns/1ps

module seg7_scanner
    import board_pkg::*, display_pkg::*;
#(
    parameter int period = 1000
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  count_t               count,
    output seg_t                 abcdefgh,
    output logic [w_digit - 1:0] digit
);

    localparam int w_cnt = (period > 1) ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;
    logic [2:0]         idx;      // Digit being shown

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt   <= '0;
            idx   <= 3'(w_digit - 1);   // So the first step lands on digit 0
            digit <= '0;
        end
        else if (cnt == w_cnt'(period - 1))
        begin
            cnt <= '0;
            if (idx == 3'(w_digit - 1))
            begin
                idx   <= '0;
                digit <= w_digit'(1);
            end
            else
            begin
                idx   <= idx + 1'b1;
                digit <= w_digit'(1) << (idx + 1'b1);
            end
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // Nibble of the selected digit, 0 is least significant
    assign abcdefgh = hex_to_seg(count[4 * idx +: 4]);

endmodule

// ==== src/seg7_static_latch.sv ====
`timescale 1ns/1ps

module seg7_static_latch
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  seg_t                 abcdefgh,
    input  logic [w_digit - 1:0] digit,
    output seg_t                 hex0,
    output seg_t                 hex1,
    output seg_t                 hex2,
    output seg_t                 hex3,
    output seg_t                 hex4,
    output seg_t                 hex5
);

    seg_t hgfedcba;
    seg_t hex_q [w_digit];

    // Board wiring wants segment a at bit 0
    always_comb
    begin
        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
    end

    // Each digit holds its pattern until scanned again
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < w_digit; i++)
                hex_q[i] <= '1;               // Blank
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
                if (digit[i])
                    hex_q[i] <= ~hgfedcba;    // Active low segments
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

// ==== src/lab_top.sv ====
`timescale 1ns/1ps

module lab_top
    import board_pkg::*, display_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   tick,
    input  key_t   key,       // Active low
    input  sw_t    sw,
    vga_if.sink    vga,
    output led_t   led,
    output count_t count,
    output rgb_t   rgb
);

    key_t key_meta;
    key_t key_sync;
    key_t key_prev;
    key_t key_press;

    logic inc;
    logic clr;

    //--------------------------------------------------------------------------
    // Key synchronizers and press detection

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end
        else
        begin
            key_meta <= ~key;         // Pressed is high from here on
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_press = key_sync & ~key_prev;
    assign inc       = key_press[0];
    assign clr       = key_press[1];

    //--------------------------------------------------------------------------
    // Counter and LED mirror

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count <= '0;
            led   <= '0;
        end
        else
        begin
            if (clr)
                count <= '0;          // Clear wins
            else if (inc || (tick && sw[0]))
                count <= count + 1'b1;

            led <= led_t'(sw);
        end
    end

    // Coordinate pattern, dark outside the visible area
    always_ff @(posedge clk)
    begin
        if (vga.display_on)
        begin
            rgb.red   <= vga.x[7:4];
            rgb.green <= vga.y[7:4];
            rgb.blue  <= sw[4:1];
        end
        else
        begin
            rgb <= '0;
        end
    end

endmodule

// ==== src/board_top.sv ====
`timescale 1ns/1ps

module board_top
    import board_pkg::*, display_pkg::*;
#(
    parameter int tick_period = default_tick_period,
    parameter int scan_period = clk_mhz * 1000     // 1 ms per digit
)
(
    input  logic   clk,
    input  logic   rst,
    input  key_t   key,
    input  sw_t    sw,
    output led_t   led,
    output seg_t   hex0,
    output seg_t   hex1,
    output seg_t   hex2,
    output seg_t   hex3,
    output seg_t   hex4,
    output seg_t   hex5,
    output logic   vga_hs,
    output logic   vga_vs,
    output color_t vga_r,
    output color_t vga_g,
    output color_t vga_b
);

    logic                 tick;
    count_t               count;
    rgb_t                 rgb;
    seg_t                 abcdefgh;     // Multiplexed segment bus
    logic [w_digit - 1:0] digit;

    vga_if vga ();

    //--------------------------------------------------------------------------

    tick_gen #(.period(tick_period)) i_tick_gen
    (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    vga_timing i_vga_timing
    (
        .clk (clk),
        .rst (rst),
        .vga (vga)
    );

    lab_top i_lab_top
    (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .key   (key),
        .sw    (sw),
        .vga   (vga),
        .led   (led),
        .count (count),
        .rgb   (rgb)
    );

    //--------------------------------------------------------------------------
    // Dynamic display drive turned into static digits

    seg7_scanner #(.period(scan_period)) i_seg7_scanner
    (
        .clk      (clk),
        .rst      (rst),
        .count    (count),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    seg7_static_latch i_seg7_static_latch
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5)
    );

    assign vga_hs = vga.hsync;
    assign vga_vs = vga.vsync;
    assign vga_r  = rgb.red;
    assign vga_g  = rgb.green;
    assign vga_b  = rgb.blue;

endmodule

// ==== dv/tb_board_top.sv ====
`timescale 1ns/1ps

module tb_board_top
    import board_pkg::*, display_pkg::*;
();

    localparam int  tick_period   = 200;
    localparam int  scan_period   = 4;
    localparam int  settle_cycles = 30;
    localparam int  tick_window   = 1000;
    localparam int  max_steps     = 32;
    localparam int  trace_cols    = 5;
    localparam int  wait_limit    = 4000;
    localparam int  line_cycles   = 800 * 2;     // 800 pixels of 2 clocks
    localparam int  sync_cycles   = 96 * 2;
    localparam sw_t vga_sw        = 9'h0b4;      // Blue nibble 4'ha

    logic   clk;
    logic   rst;
    key_t   key;
    sw_t    sw;
    led_t   led;
    seg_t   hex0;
    seg_t   hex1;
    seg_t   hex2;
    seg_t   hex3;
    seg_t   hex4;
    seg_t   hex5;
    logic   vga_hs;
    logic   vga_vs;
    color_t vga_r;
    color_t vga_g;
    color_t vga_b;

    logic [31:0] trace_mem [trace_cols * max_steps];

    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_start_errors;
    bit     timed_out;
    count_t last_count;    // Count after the previous step

    board_top #(.tick_period(tick_period), .scan_period(scan_period)) i_board_top
    (
        .clk    (clk),
        .rst    (rst),
        .key    (key),
        .sw     (sw),
        .led    (led),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .hex4   (hex4),
        .hex5   (hex5),
        .vga_hs (vga_hs),
        .vga_vs (vga_vs),
        .vga_r  (vga_r),
        .vga_g  (vga_g),
        .vga_b  (vga_b)
    );

    always #5 clk = ~clk;

    //--------------------------------------------------------------------------
    // Expected digit patterns

    function automatic seg_t board_pattern(input logic [3:0] nibble);
        seg_t glyph;
        seg_t result;
        glyph = hex_to_seg(nibble);
        for (int i = 0; i < 8; i++)
            result[i] = ~glyph[7 - i];    // Reversed and active low
        return result;
    endfunction

    function automatic seg_t digit_value(input int n);
        case (n)
            0:       return hex0;
            1:       return hex1;
            2:       return hex2;
            3:       return hex3;
            4:       return hex4;
            default: return hex5;
        endcase
    endfunction

    // Reads the count back from the six digits
    function automatic bit decode_digits(output count_t value);
        bit found;
        bit ok;
        value = '0;
        ok    = 1'b1;
        for (int n = 0; n < w_digit; n++)
        begin
            found = 1'b0;
            for (int v = 0; v < 16; v++)
                if (!found && digit_value(n) == board_pattern(4'(v)))
                begin
                    value[4 * n +: 4] = 4'(v);
                    found             = 1'b1;
                end
            ok = ok && found;
        end
        return ok;
    endfunction

    //--------------------------------------------------------------------------
    // Compare tasks

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: led is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input count_t got, input count_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp)
        begin
            errors++;
            $display("error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errors || timed_out)
        begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - test_start_errors);
        end
        else
        begin
            $display("test %s: ok", name);
        end
    endtask

    // Counts cycles until vga_hs changes to level
    task automatic wait_hs(input logic level, output int cycles);
        logic prev;
        prev   = vga_hs;
        cycles = 0;
        while (!timed_out)
        begin
            @(negedge clk);
            cycles++;
            if (prev !== level && vga_hs === level)
                break;
            prev = vga_hs;
            if (cycles >= wait_limit)
            begin
                timed_out = 1'b1;
                $display("timeout: vga_hs did not go %s within %0d cycles",
                         level ? "high" : "low", wait_limit);
            end
        end
    endtask

    //--------------------------------------------------------------------------
    // One trace line

    task automatic run_step(input int n);
        int     base;
        int     hold;
        key_t   step_key;
        sw_t    step_sw;
        count_t exp_count;
        led_t   exp_led;
        count_t shown;
        count_t later;
        base      = trace_cols * n;
        step_key  = key_t'(trace_mem[base]);
        step_sw   = sw_t'(trace_mem[base + 1]);
        hold      = int'(trace_mem[base + 2]);
        exp_count = count_t'(trace_mem[base + 3]);
        exp_led   = led_t'(trace_mem[base + 4]);
        begin_test();
        @(posedge clk);
        key <= step_key;
        sw  <= step_sw;
        repeat (hold) @(posedge clk);
        @(negedge clk);
        check_led(led, exp_led);
        @(posedge clk);
        if (step_sw[0])
        begin
            sw <= step_sw & ~sw_t'(1);    // Stop tick counting
            repeat (settle_cycles) @(posedge clk);
            @(negedge clk);
            if (!decode_digits(shown))
            begin
                errors++;
                $display("the digits do not show hex glyphs after tick counting");
            end
            else if (shown <= last_count || shown > exp_count)
            begin
                errors++;
                $display("error at %0t: count is %h, expected above %h and at most %h",
                         $time, shown, last_count, exp_count);
            end
            repeat (tick_window) @(posedge clk);
            @(negedge clk);
            void'(decode_digits(later));
            check_count(later, shown, "count with ticks off");
            last_count = shown;
        end
        else
        begin
            key <= '1;
            repeat (hold + settle_cycles) @(posedge clk);
            @(negedge clk);
            for (int d = 0; d < w_digit; d++)
                check_seg(digit_value(d), board_pattern(exp_count[4 * d +: 4]),
                          $sformatf("hex%0d", d));
            last_count = exp_count;
        end
        end_test($sformatf("step %0d", n));
    endtask

    //--------------------------------------------------------------------------
    // Horizontal timing, blanking and blue channel

    task automatic run_line_test();
        int lows;
        int cycles;
        begin_test();
        @(posedge clk);
        sw <= vga_sw;
        @(negedge clk);
        wait_hs(1'b0, cycles);
        lows = 0;
        while (vga_hs === 1'b0 && !timed_out)
        begin
            check_rgb(rgb_t'({vga_r, vga_g, vga_b}), '0, "rgb in sync");
            @(negedge clk);
            lows++;
            if (lows > wait_limit)
            begin
                timed_out = 1'b1;
                $display("timeout: vga_hs stayed low for %0d cycles", wait_limit);
            end
        end
        check_cycles(lows, sync_cycles, "hsync width");
        repeat (200) @(negedge clk);      // Past the back porch
        for (int i = 0; i < 1000; i++)
        begin
            @(negedge clk);
            check_color(vga_b, vga_sw[4:1], "vga_b");
        end
        wait_hs(1'b0, cycles);
        check_cycles(lows + 1200 + cycles, line_cycles, "hsync period");
        end_test("line timing");
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        key          = '1;
        sw           = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        last_count   = '0;
        for (int i = 0; i < trace_cols * max_steps; i++)
            trace_mem[i] = 32'hffff_0000 | 32'(i);    // Words the file did not set
        $readmemh("dv/board_trace.txt", trace_mem);

        begin_test();
        repeat (9) @(posedge clk);
        @(negedge clk);
        for (int d = 0; d < w_digit; d++)
            check_seg(digit_value(d), 8'hff, $sformatf("hex%0d in reset", d));
        check_led(led, '0);
        check_level(vga_hs, 1'b1, "vga_hs in reset");
        check_level(vga_vs, 1'b1, "vga_vs in reset");
        @(posedge clk);
        rst <= 1'b0;
        end_test("reset");

        for (int n = 0; n < max_steps; n++)
        begin
            if (trace_mem[trace_cols * n] === 32'hf)
                break;
            if (trace_mem[trace_cols * n][31:16] === 16'hffff)
            begin
                errors++;
                $display("the trace file ends without its end line");
                break;
            end
            run_step(n);
        end

        run_line_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (timed_out || errors != 0 || tests_failed != 0)
            $display("*** TEST FAILED ***");
        else
            $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== dv/board_trace.txt ====
// key sw hold count led (hex), key is active low, key f ends the trace
// A line with sw[0] high counts ticks, its count is the upper bound
2 000 0010 000001 000
2 0a2 0010 000002 0a2
2 154 0014 000003 154
1 1fe 0010 000000 1fe
2 0f0 0008 000001 0f0
2 00e 0008 000002 00e
2 1aa 0010 000003 1aa
3 0c8 0010 000003 0c8
1 000 0010 000000 000
3 001 03e8 000005 001
1 0b4 0010 000000 0b4
f 000 0000 000000 000

// ==== compile.f ====
src/board_pkg.sv
src/display_pkg.sv
src/vga_if.sv
src/tick_gen.sv
src/vga_timing.sv
src/seg7_scanner.sv
src/seg7_static_latch.sv
src/lab_top.sv
src/board_top.sv
dv/tb_board_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_board_top -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_board_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
fi
exit 1
